//--- hdl/sys_io_pkg.sv
// Host I/O port definitions shared by the command decoder and the top level
// Command byte sits in the low byte of the first word after uio rises
`default_nettype none

package sys_io_pkg;

	// ====================
	// Host words and commands
	typedef logic [15:0] io_word_t;
	typedef logic [7:0]  io_cmd_t;

	localparam io_cmd_t CMD_LED = 8'h25;
	localparam io_cmd_t CMD_VOL = 8'h26;

	// Mask in the upper byte, LED state in the lower byte
	typedef struct packed {
		logic [7:0] overtake;
		logic [7:0] state;
	} led_word_s;

	typedef struct packed {
		logic [10:0] rsvd;
		logic        mute;
		logic [3:0]  shift;
	} vol_word_s;

	// Same data word, read according to the held command
	typedef union packed {
		io_word_t  raw;
		led_word_s led;
		vol_word_s vol;
	} io_word_u;

	// Input synchronizer depth for the host port
	localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire

//--- hdl/sys_audio_pkg.sv
// Audio path types for the stereo mix and volume stage
// Samples are 16 bit, signed or unsigned as flagged by the core
`default_nettype none

package sys_audio_pkg;

	// ====================
	// Sample format
	typedef logic [15:0] sample_t;

	// Cross-mix amount between left and right
	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_1_8  = 2'd1,
		MIX_1_4  = 2'd2,
		MIX_HALF = 2'd3
	} mix_mode_t;

	// Volume attenuation as a right shift count
	typedef logic [3:0] att_shift_t;

endpackage

`default_nettype wire

//--- hdl/sys_cfg_if.sv
// Host-set settings, written by the command decoder only
// All fields are plain levels, cleared by reset in the decoder
`default_nettype none

interface sys_cfg_if;
	import sys_audio_pkg::*;

	logic [7:0] led_overtake;
	logic [7:0] led_state;
	logic       vol_mute;
	att_shift_t vol_shift;

	modport ctrl (output led_overtake, output led_state, output vol_mute, output vol_shift);

	// Volume side
	modport audio (input vol_mute, input vol_shift);

	// LED side
	modport leds (input led_overtake, input led_state);

endinterface

`default_nettype wire

//--- hdl/host_cmd_decoder.sv
// Host command port decoder, all logic on clk_sys
// io_clk must hold each phase for at least three clk_sys cycles
// Only LED and volume commands act, the rest are accepted and dropped
`default_nettype none

module host_cmd_decoder (
	input  wire                   clk_sys,
	input  wire                   resetd,
	input  wire                   i_io_clk,
	input  wire                   i_io_uio,
	input  wire sys_io_pkg::io_word_t i_io_din,
	input  wire                   i_io_wait,
	output logic                  o_io_ack,
	sys_cfg_if.ctrl               cfg
);
	import sys_io_pkg::*;

	logic [SYNC_STAGES-1:0] clk_sync;
	logic [SYNC_STAGES-1:0] uio_sync;
	io_word_t               din_sync [SYNC_STAGES];

	logic     io_clk_s;
	logic     io_uio_s;
	io_word_u host_word;

	logic    rack;
	logic    strobe_raw;
	logic    io_strobe;
	logic    has_cmd;
	io_cmd_t cmd;

	// ====================
	// Input synchronizers
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			clk_sync <= '0;
			uio_sync <= '0;
		end else begin
			clk_sync <= {clk_sync[SYNC_STAGES-2:0], i_io_clk};
			uio_sync <= {uio_sync[SYNC_STAGES-2:0], i_io_uio};
		end
	end

	// Data word follows the same path, stable while io_clk is high
	always_ff @(posedge clk_sys) begin
		din_sync[0] <= i_io_din;
		for (int i = 1; i < SYNC_STAGES; i++) begin
			din_sync[i] <= din_sync[i-1];
		end
	end

	assign io_clk_s      = clk_sync[SYNC_STAGES-1];
	assign io_uio_s      = uio_sync[SYNC_STAGES-1];
	assign host_word.raw = din_sync[SYNC_STAGES-1];

	// ====================
	// Strobe and acknowledge
	// rack remembers the io clock level already seen
	assign strobe_raw = ~rack & io_clk_s;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			rack      <= 1'b0;
			o_io_ack  <= 1'b0;
			io_strobe <= 1'b0;
		end else begin
			io_strobe <= strobe_raw;
			// Core wait holds the ack, host stalls until it moves
			if (~i_io_wait | strobe_raw) begin
				rack     <= io_clk_s;
				o_io_ack <= rack;
			end
		end
	end

	// ====================
	// Command decode
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd          <= 1'b0;
			cmd              <= '0;
			cfg.led_overtake <= '0;
			cfg.led_state    <= '0;
			cfg.vol_mute     <= 1'b0;
			cfg.vol_shift    <= '0;
		end else if (!io_uio_s) begin
			has_cmd <= 1'b0;
		end else if (io_strobe) begin
			if (!has_cmd) begin
				// First word carries the command
				has_cmd <= 1'b1;
				cmd     <= host_word.raw[7:0];
			end else begin
				case (cmd)
					CMD_LED: begin
						cfg.led_overtake <= host_word.led.overtake;
						cfg.led_state    <= host_word.led.state;
					end
					CMD_VOL: begin
						cfg.vol_mute  <= host_word.vol.mute;
						cfg.vol_shift <= host_word.vol.shift;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/audio_mixer.sv
// Stereo cross-mix and volume, fixed latency of two clk_sys cycles
// Sums wrap at 16 bits, there is no saturation
// i_audio_s picks arithmetic or logical shifts for the whole sample
`default_nettype none

module audio_mixer (
	input  wire                           clk_sys,
	input  wire                           resetd,
	input  wire sys_audio_pkg::sample_t   i_audio_l,
	input  wire sys_audio_pkg::sample_t   i_audio_r,
	input  wire                           i_audio_s,
	input  wire sys_audio_pkg::mix_mode_t i_audio_mix,
	output sys_audio_pkg::sample_t        o_audio_l,
	output sys_audio_pkg::sample_t        o_audio_r,
	sys_cfg_if.audio                      cfg
);
	import sys_audio_pkg::*;

	sample_t mix_l;
	sample_t mix_r;
	logic    arith_q;

	function automatic sample_t shift_r(input sample_t v, input att_shift_t n,
		input logic arith);
		if (arith)
			return sample_t'($signed(v) >>> n);
		return v >> n;
	endfunction

	// own is the channel being built, other is the opposite channel
	function automatic sample_t mix_chan(input sample_t own, input sample_t other,
		input mix_mode_t mode, input logic arith);
		sample_t res;
		res = own;
		case (mode)
			MIX_1_8:  res = own - shift_r(own, 4'd3, arith) + shift_r(other, 4'd3, arith);
			MIX_1_4:  res = own - shift_r(own, 4'd2, arith) + shift_r(other, 4'd2, arith);
			MIX_HALF: res = shift_r(own, 4'd1, arith) + shift_r(other, 4'd1, arith);
			default:  res = own;
		endcase
		return res;
	endfunction

	// ====================
	// Stage 1, cross-mix
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			mix_l   <= '0;
			mix_r   <= '0;
			arith_q <= 1'b0;
		end else begin
			mix_l   <= mix_chan(i_audio_l, i_audio_r, i_audio_mix, i_audio_s);
			mix_r   <= mix_chan(i_audio_r, i_audio_l, i_audio_mix, i_audio_s);
			// Sign mode travels with its sample
			arith_q <= i_audio_s;
		end
	end

	// ====================
	// Stage 2, attenuation and mute
	always_ff @(posedge clk_sys) begin
		if (resetd || cfg.vol_mute) begin
			o_audio_l <= '0;
			o_audio_r <= '0;
		end else begin
			o_audio_l <= shift_r(mix_l, cfg.vol_shift, arith_q);
			o_audio_r <= shift_r(mix_r, cfg.vol_shift, arith_q);
		end
	end

endmodule

`default_nettype wire

//--- hdl/board_io.sv
// Board buttons and LEDs, DEB_DIV must be at least 1
// A button changes after 8 equal samples, one sample every DEB_DIV+1 cycles
`default_nettype none

module board_io #(
	parameter int DEB_DIV = 100000
) (
	input  wire        clk_sys,
	input  wire        resetd,
	input  wire        i_btn_user_n,
	input  wire        i_btn_osd_n,
	input  wire        i_led_user,
	input  wire  [1:0] i_led_power,
	input  wire  [1:0] i_led_disk,
	output logic       o_btn_user,
	output logic       o_btn_osd,
	output logic [7:0] o_led,
	output logic       o_led_user_n,
	output logic       o_led_hdd_n,
	output logic       o_led_power_n,
	sys_cfg_if.leds    cfg
);
	localparam int DIV_W = (DEB_DIV > 0) ? $clog2(DEB_DIV + 1) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic             tick;

	// Index 0 is user, index 1 is osd
	logic [1:0] btn_meta;
	logic [1:0] btn_sync;
	logic [7:0] deb_hist [2];
	logic [1:0] btn_q;

	logic       power_act;
	logic       disk_act;
	logic       user_act;
	logic [7:0] led_default;

	// ====================
	// Debounce sample tick
	assign tick = (div_cnt == DIV_W'(DEB_DIV));

	always_ff @(posedge clk_sys) begin
		if (resetd || tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// Buttons are asynchronous, pressed reads as 1
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			btn_meta <= '0;
			btn_sync <= '0;
		end else begin
			btn_meta <= {~i_btn_osd_n, ~i_btn_user_n};
			btn_sync <= btn_meta;
		end
	end

	always_ff @(posedge clk_sys) begin
		logic [7:0] hist_next;
		if (resetd) begin
			deb_hist[0] <= '0;
			deb_hist[1] <= '0;
			btn_q       <= '0;
		end else if (tick) begin
			for (int i = 0; i < 2; i++) begin
				hist_next = {deb_hist[i][6:0], btn_sync[i]};
				deb_hist[i] <= hist_next;
				// Mixed history keeps the old level
				if (&hist_next)
					btn_q[i] <= 1'b1;
				else if (hist_next == '0)
					btn_q[i] <= 1'b0;
			end
		end
	end

	assign o_btn_user = btn_q[0];
	assign o_btn_osd  = btn_q[1];

	// ====================
	// LED drives
	assign power_act = i_led_power[1] & i_led_power[0];
	assign disk_act  = (i_led_disk[1] & i_led_disk[0]) | (~i_led_disk[1] & i_led_disk[0]);
	assign user_act  = i_led_user;

	assign o_led_power_n = ~power_act;
	assign o_led_hdd_n   = ~disk_act;
	assign o_led_user_n  = ~user_act;

	// Host mask picks its own state bit over the status pattern
	assign led_default = {3'b000, power_act, 1'b0, disk_act, 1'b0, user_act};
	assign o_led       = (cfg.led_overtake & cfg.led_state) | (~cfg.led_overtake & led_default);

endmodule

`default_nettype wire

//--- hdl/sys_top.sv
// Host I/O side of the board top level, single clock clk_sys
// resetd is synchronous and active high
// LED pins are plain active-low outputs, no open drain
`default_nettype none

module sys_top #(
	parameter int DEB_DIV = 100000
) (
	input  wire                           clk_sys,
	input  wire                           resetd,

	// Host port
	input  wire                           i_io_clk,
	input  wire                           i_io_uio,
	input  wire sys_io_pkg::io_word_t     i_io_din,
	input  wire                           i_io_wait,
	output wire                           o_io_ack,

	// Core audio
	input  wire sys_audio_pkg::sample_t   i_audio_l,
	input  wire sys_audio_pkg::sample_t   i_audio_r,
	input  wire                           i_audio_s,
	input  wire sys_audio_pkg::mix_mode_t i_audio_mix,
	output wire sys_audio_pkg::sample_t   o_audio_l,
	output wire sys_audio_pkg::sample_t   o_audio_r,

	// Core status and board I/O
	input  wire                           i_led_user,
	input  wire [1:0]                     i_led_power,
	input  wire [1:0]                     i_led_disk,
	input  wire                           i_btn_user_n,
	input  wire                           i_btn_osd_n,
	output wire                           o_btn_user,
	output wire                           o_btn_osd,
	output wire [7:0]                     o_led,
	output wire                           o_led_user_n,
	output wire                           o_led_hdd_n,
	output wire                           o_led_power_n
);

	sys_cfg_if u_cfg_if ();

	// ====================
	// Host commands
	host_cmd_decoder u_host_cmd_decoder (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_io_clk  (i_io_clk),
		.i_io_uio  (i_io_uio),
		.i_io_din  (i_io_din),
		.i_io_wait (i_io_wait),
		.o_io_ack  (o_io_ack),
		.cfg       (u_cfg_if.ctrl)
	);

	// ====================
	// Audio
	audio_mixer u_audio_mixer (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_audio_l   (i_audio_l),
		.i_audio_r   (i_audio_r),
		.i_audio_s   (i_audio_s),
		.i_audio_mix (i_audio_mix),
		.o_audio_l   (o_audio_l),
		.o_audio_r   (o_audio_r),
		.cfg         (u_cfg_if.audio)
	);

	// ====================
	// Buttons and LEDs
	board_io #(
		.DEB_DIV (DEB_DIV)
	) u_board_io (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_btn_user_n  (i_btn_user_n),
		.i_btn_osd_n   (i_btn_osd_n),
		.i_led_user    (i_led_user),
		.i_led_power   (i_led_power),
		.i_led_disk    (i_led_disk),
		.o_btn_user    (o_btn_user),
		.o_btn_osd     (o_btn_osd),
		.o_led         (o_led),
		.o_led_user_n  (o_led_user_n),
		.o_led_hdd_n   (o_led_hdd_n),
		.o_led_power_n (o_led_power_n),
		.cfg           (u_cfg_if.leds)
	);

endmodule

`default_nettype wire

//--- sim/sys_top_sva.sv
// Assertions bound into sys_top, reaching into the decoder and the settings interface
// Relies on the decoder signal name io_clk_s
`default_nettype none

module sys_top_sva (
	input wire                         clk_sys,
	input wire                         resetd,
	input wire                         i_io_wait,
	input wire                         io_clk_s,
	input wire                         o_io_ack,
	input wire                         vol_mute,
	input wire sys_audio_pkg::sample_t o_audio_l,
	input wire sys_audio_pkg::sample_t o_audio_r,
	input wire                         o_btn_user,
	input wire                         o_btn_osd
);
	timeunit 1ns;
	timeprecision 100ps;

	// Ack only moves without wait or on a new io clock edge
	ack_hold: assert property (@(posedge clk_sys) disable iff (resetd)
		i_io_wait && !$rose(io_clk_s) |=> $stable(o_io_ack))
		else $error("o_io_ack changed while i_io_wait was high");

	// Mute clears the output register on the next edge
	mute_zero: assert property (@(posedge clk_sys) disable iff (resetd)
		vol_mute |=> (o_audio_l == '0 && o_audio_r == '0))
		else $error("audio output not zero while muted");

	reset_zero: assert property (@(posedge clk_sys)
		resetd |=> (!o_io_ack && o_audio_l == '0 && o_audio_r == '0
			&& !o_btn_user && !o_btn_osd))
		else $error("outputs not cleared after reset");

endmodule

bind sys_top sys_top_sva u_sys_top_sva (
	.clk_sys    (clk_sys),
	.resetd     (resetd),
	.i_io_wait  (i_io_wait),
	.io_clk_s   (u_host_cmd_decoder.io_clk_s),
	.o_io_ack   (o_io_ack),
	.vol_mute   (u_cfg_if.vol_mute),
	.o_audio_l  (o_audio_l),
	.o_audio_r  (o_audio_r),
	.o_btn_user (o_btn_user),
	.o_btn_osd  (o_btn_osd)
);

`default_nettype wire

//--- sim/tb_sys_top.sv
// Testbench for sys_top, built with DEB_DIV = 3 so debounce ticks come every 4 cycles
// Audio outputs are compared with a reference model two cycles after each sample
// Host words use io clock phases of IO_PHASE cycles, well above the decoder minimum
`default_nettype none

module tb_sys_top;
	timeunit 1ns;
	timeprecision 100ps;

	import sys_io_pkg::*;
	import sys_audio_pkg::*;

	localparam int DEB_DIV    = 3;
	localparam int TICK       = DEB_DIV + 1;
	localparam int IO_PHASE   = 8;
	localparam int HOST_CYC   = 6 * IO_PHASE + 1;
	localparam int N_SAMPLES  = 64;
	localparam int AUDIO_CYC  = 11 * (HOST_CYC + N_SAMPLES + 4);
	localparam int LED_CYC    = 2 * (HOST_CYC + 32);
	localparam int BTN_CYC    = 2 * 54 * TICK;
	localparam int MAX_CYCLES = AUDIO_CYC + LED_CYC + BTN_CYC + 100 + 20000;

	// One applied sample with the settings it must see
	typedef struct packed {
		logic       valid;
		sample_t    l;
		sample_t    r;
		mix_mode_t  mix;
		logic       sgn;
		logic       mute;
		att_shift_t shift;
	} aud_entry_t;

	logic       clk_sys;
	logic       resetd;
	logic       i_io_clk;
	logic       i_io_uio;
	io_word_t   i_io_din;
	logic       i_io_wait;
	logic       o_io_ack;
	sample_t    i_audio_l, i_audio_r;
	logic       i_audio_s;
	mix_mode_t  i_audio_mix;
	sample_t    o_audio_l, o_audio_r;
	logic       i_led_user;
	logic [1:0] i_led_power, i_led_disk;
	logic       i_btn_user_n, i_btn_osd_n;
	logic       o_btn_user, o_btn_osd;
	logic [7:0] o_led;
	logic       o_led_user_n, o_led_hdd_n, o_led_power_n;

	integer     seed;
	int         check_cnt, mismatch_cnt, other_cnt, cycle_cnt;
	logic       audio_chk;
	logic       exp_mute;
	att_shift_t exp_shift;
	logic [7:0] exp_overtake, exp_state;
	aud_entry_t pipe_q[$];

	sys_top #(.DEB_DIV(DEB_DIV)) u_sys_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ====================
	// Reference model
	// Divide by 2**k on a 32-bit extended copy, sign or zero fill
	function automatic sample_t scale_down(input sample_t v, input int k, input logic sgn);
		logic [31:0] ext;
		ext = sgn ? {{16{v[15]}}, v} : {16'h0000, v};
		ext = ext >> k;
		return ext[15:0];
	endfunction

	function automatic sample_t ref_mix_att(input sample_t own, input sample_t other,
		input mix_mode_t mode, input logic sgn, input logic mute, input att_shift_t shift);
		sample_t mixed;
		int      k;
		k = (mode == MIX_1_8) ? 3 : 2;
		if (mode == MIX_NONE)
			mixed = own;
		else if (mode == MIX_HALF)
			mixed = scale_down(own, 1, sgn) + scale_down(other, 1, sgn);
		else
			mixed = own - scale_down(own, k, sgn) + scale_down(other, k, sgn);
		if (mute)
			return '0;
		return scale_down(mixed, int'(shift), sgn);
	endfunction

	function automatic logic [7:0] ref_led_pattern(input logic [7:0] mask,
		input logic [7:0] state, input logic user, input logic [1:0] power,
		input logic [1:0] disk);
		logic [7:0] pattern;
		pattern    = 8'h00;
		pattern[0] = user;
		pattern[2] = (disk == 2'b11) || (disk == 2'b01);
		pattern[4] = (power == 2'b11);
		return (state & mask) | (pattern & ~mask);
	endfunction

	// ====================
	// Compare tasks
	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		check_cnt++;
		if (got !== exp) begin
			mismatch_cnt++;
			$display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_led(input logic [7:0] got, input logic [7:0] exp);
		check_cnt++;
		if (got !== exp) begin
			mismatch_cnt++;
			$display("Mismatch o_led: got %h, expected %h at %0t", got, exp, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_cnt++;
		if (got !== exp) begin
			mismatch_cnt++;
			$display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	function automatic logic [15:0] rand16();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// ====================
	// Host port
	task automatic io_clock_word(input io_word_t w);
		i_io_din <= w;
		i_io_clk <= 1'b1;
		repeat (IO_PHASE) @(posedge clk_sys);
		i_io_clk <= 1'b0;
		repeat (IO_PHASE) @(posedge clk_sys);
	endtask

	task automatic send_host(input io_cmd_t cmd, input io_word_t data);
		@(posedge clk_sys);
		i_io_uio <= 1'b1;
		repeat (IO_PHASE) @(posedge clk_sys);
		io_clock_word({8'h00, cmd});
		io_clock_word(data);
		i_io_uio <= 1'b0;
		repeat (IO_PHASE) @(posedge clk_sys);
	endtask

	task automatic set_volume(input logic mute, input att_shift_t shift);
		send_host(CMD_VOL, {11'h000, mute, shift});
		exp_mute  = mute;
		exp_shift = shift;
	endtask

	// New sample on every cycle, mode and sign fixed for the block
	task automatic run_samples(input mix_mode_t mode, input logic sgn, input int n);
		repeat (n) begin
			@(posedge clk_sys);
			i_audio_l   <= rand16();
			i_audio_r   <= rand16();
			i_audio_mix <= mode;
			i_audio_s   <= sgn;
			audio_chk = 1'b1;
		end
		@(posedge clk_sys);
		audio_chk = 1'b0;
	endtask

	// Samples travel two stages, so compare against the entry two cycles old
	initial begin
		aud_entry_t ent;
		aud_entry_t head;
		forever begin
			@(negedge clk_sys);
			ent = '{audio_chk, i_audio_l, i_audio_r, i_audio_mix, i_audio_s, exp_mute,
				exp_shift};
			pipe_q.push_back(ent);
			if (pipe_q.size() > 2) begin
				head = pipe_q.pop_front();
				if (head.valid) begin
					check_sample("o_audio_l", o_audio_l,
						ref_mix_att(head.l, head.r, head.mix, head.sgn, head.mute, head.shift));
					check_sample("o_audio_r", o_audio_r,
						ref_mix_att(head.r, head.l, head.mix, head.sgn, head.mute, head.shift));
				end
			end
		end
	end

	// ====================
	// Buttons
	function automatic logic btn_out(input int sel);
		return (sel == 0) ? o_btn_user : o_btn_osd;
	endfunction

	task automatic press(input int sel, input logic down);
		@(posedge clk_sys);
		if (sel == 0)
			i_btn_user_n <= ~down;
		else
			i_btn_osd_n <= ~down;
	endtask

	// Output change ends the wait, 12 ticks at most
	task automatic wait_button(input int sel, input logic level);
		int n;
		n = 0;
		while (btn_out(sel) !== level && n < 12 * TICK) begin
			@(negedge clk_sys);
			n++;
		end
		if (btn_out(sel) !== level) begin
			other_cnt++;
			$display("Button %0d did not go to %0b within 12 debounce ticks", sel, level);
		end
	endtask

	task automatic hold_button(input int sel, input logic level, input int ticks);
		repeat (ticks * TICK) begin
			@(negedge clk_sys);
			if (sel == 0)
				check_bit("o_btn_user", o_btn_user, level);
			else
				check_bit("o_btn_osd", o_btn_osd, level);
		end
	endtask

	task automatic test_button(input int sel);
		press(sel, 1'b1);
		wait_button(sel, 1'b1);
		// Short release glitch
		press(sel, 1'b0);
		hold_button(sel, 1'b1, 3);
		press(sel, 1'b1);
		hold_button(sel, 1'b1, 12);
		press(sel, 1'b0);
		wait_button(sel, 1'b0);
		// Short press glitch
		press(sel, 1'b1);
		hold_button(sel, 1'b0, 3);
		press(sel, 1'b0);
		hold_button(sel, 1'b0, 12);
	endtask

	// ====================
	// Wait back-pressure on the acknowledge
	task automatic test_wait();
		logic held;
		int   n;
		@(posedge clk_sys);
		i_io_clk <= 1'b1;
		repeat (2 * IO_PHASE) @(posedge clk_sys);
		i_io_wait <= 1'b1;
		@(negedge clk_sys);
		held = o_io_ack;
		check_bit("o_io_ack", held, 1'b1);
		repeat (5) begin
			@(posedge clk_sys);
			i_io_clk <= ~i_io_clk;
			repeat (IO_PHASE) begin
				@(negedge clk_sys);
				check_bit("o_io_ack", o_io_ack, held);
			end
		end
		@(posedge clk_sys);
		i_io_wait <= 1'b0;
		n = 0;
		while (o_io_ack !== i_io_clk && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		if (o_io_ack !== i_io_clk) begin
			other_cnt++;
			$display("o_io_ack did not follow i_io_clk after wait was released");
		end
	endtask

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	// ====================
	// Test sequence
	initial begin
		logic [15:0] led_word;
		seed         = 32'h48a4;
		check_cnt    = 0;
		mismatch_cnt = 0;
		other_cnt    = 0;
		audio_chk    = 1'b0;
		exp_mute     = 1'b0;
		exp_shift    = '0;
		exp_overtake = 8'h00;
		exp_state    = 8'h00;
		resetd       = 1'b1;
		i_io_clk     = 1'b0;
		i_io_uio     = 1'b0;
		i_io_din     = '0;
		i_io_wait    = 1'b0;
		i_audio_l    = '0;
		i_audio_r    = '0;
		i_audio_s    = 1'b0;
		i_audio_mix  = MIX_NONE;
		i_led_user   = 1'b1;
		i_led_power  = 2'b11;
		i_led_disk   = 2'b01;
		i_btn_user_n = 1'b1;
		i_btn_osd_n  = 1'b1;
		repeat (3) @(posedge clk_sys);
		resetd <= 1'b0;

		@(negedge clk_sys);
		check_bit("o_io_ack", o_io_ack, 1'b0);
		check_bit("o_btn_user", o_btn_user, 1'b0);
		check_sample("o_audio_l", o_audio_l, '0);
		check_sample("o_audio_r", o_audio_r, '0);
		check_led(o_led, ref_led_pattern(8'h00, 8'h00, i_led_user, i_led_power, i_led_disk));

		for (int b = 0; b < 8; b++) begin
			set_volume(1'b0, att_shift_t'(rand16()));
			run_samples(mix_mode_t'(b % 4), b >= 4, N_SAMPLES);
		end

		set_volume(1'b1, 4'h0);
		run_samples(MIX_1_4, 1'b1, N_SAMPLES);
		// 0x01 is not decoded, mute must survive it
		send_host(8'h01, 16'h0000);
		run_samples(MIX_HALF, 1'b0, N_SAMPLES);
		set_volume(1'b0, att_shift_t'(rand16()));
		run_samples(MIX_1_8, 1'b1, N_SAMPLES);

		repeat (2) begin
			led_word = rand16();
			send_host(CMD_LED, led_word);
			exp_overtake = led_word[15:8];
			exp_state    = led_word[7:0];
			for (int c = 0; c < 32; c++) begin
				@(posedge clk_sys);
				i_led_user  <= c[0];
				i_led_power <= c[2:1];
				i_led_disk  <= c[4:3];
				@(negedge clk_sys);
				check_led(o_led, ref_led_pattern(exp_overtake, exp_state, i_led_user,
					i_led_power, i_led_disk));
				check_bit("o_led_power_n", o_led_power_n, !(i_led_power == 2'b11));
				check_bit("o_led_hdd_n", o_led_hdd_n,
					!((i_led_disk == 2'b11) || (i_led_disk == 2'b01)));
				check_bit("o_led_user_n", o_led_user_n, !i_led_user);
			end
		end

		test_button(0);
		test_button(1);
		test_wait();

		repeat (4) @(posedge clk_sys);
		$display("Checks %0d, mismatches %0d, other errors %0d", check_cnt, mismatch_cnt,
			other_cnt);
		if (mismatch_cnt + other_cnt == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
hdl/sys_io_pkg.sv
hdl/sys_audio_pkg.sv
hdl/sys_cfg_if.sv
hdl/host_cmd_decoder.sv
hdl/audio_mixer.sv
hdl/board_io.sv
hdl/sys_top.sv
sim/sys_top_sva.sv
sim/tb_sys_top.sv

//--- Makefile
# Verilator build and run of the sys_top testbench
# Variables can be overridden on the command line, e.g. make run LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_sys_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0

FAIL_MSG  := *** FAILED ***
PASS_MSG  := *** PASSED ***
SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q -F '$(FAIL_MSG)' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q -F '$(PASS_MSG)' $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
